// ==== design/mips_pkg.sv ====
package mips_pkg;

    localparam int XLEN = 32;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'd0;
    localparam logic [5:0] OP_REGIMM  = 6'd1;
    localparam logic [5:0] OP_BEQ     = 6'd4;
    localparam logic [5:0] OP_BNE     = 6'd5;
    localparam logic [5:0] OP_BLEZ    = 6'd6;
    localparam logic [5:0] OP_BGTZ    = 6'd7;
    localparam logic [5:0] OP_ADDI    = 6'd8;
    localparam logic [5:0] OP_ADDIU   = 6'd9;
    localparam logic [5:0] OP_SLTI    = 6'd10;
    localparam logic [5:0] OP_SLTIU   = 6'd11;
    localparam logic [5:0] OP_ANDI    = 6'd12;
    localparam logic [5:0] OP_ORI     = 6'd13;
    localparam logic [5:0] OP_XORI    = 6'd14;
    localparam logic [5:0] OP_LUI     = 6'd15;
    localparam logic [5:0] OP_LB      = 6'd32;
    localparam logic [5:0] OP_LH      = 6'd33;
    localparam logic [5:0] OP_LW      = 6'd34;
    localparam logic [5:0] OP_LBU     = 6'd36;
    localparam logic [5:0] OP_LHU     = 6'd37;
    localparam logic [5:0] OP_SB      = 6'd40;
    localparam logic [5:0] OP_SH      = 6'd41;
    localparam logic [5:0] OP_SW      = 6'd43;

    // SPECIAL funct field, instr[5:0]
    localparam logic [5:0] FN_SLL   = 6'd0;
    localparam logic [5:0] FN_SRL   = 6'd2;
    localparam logic [5:0] FN_SRA   = 6'd3;
    localparam logic [5:0] FN_SLLV  = 6'd4;
    localparam logic [5:0] FN_SRLV  = 6'd6;
    localparam logic [5:0] FN_SRAV  = 6'd7;
    localparam logic [5:0] FN_MFHI  = 6'd16;
    localparam logic [5:0] FN_MTHI  = 6'd17;
    localparam logic [5:0] FN_MFLO  = 6'd18;
    localparam logic [5:0] FN_MTLO  = 6'd19;
    localparam logic [5:0] FN_MULT  = 6'd24;
    localparam logic [5:0] FN_MULTU = 6'd25;
    localparam logic [5:0] FN_DIV   = 6'd26;
    localparam logic [5:0] FN_DIVU  = 6'd27;
    localparam logic [5:0] FN_ADD   = 6'd32;
    localparam logic [5:0] FN_ADDU  = 6'd33;
    localparam logic [5:0] FN_SUB   = 6'd34;
    localparam logic [5:0] FN_SUBU  = 6'd35;
    localparam logic [5:0] FN_AND   = 6'd36;
    localparam logic [5:0] FN_OR    = 6'd37;
    localparam logic [5:0] FN_XOR   = 6'd38;
    localparam logic [5:0] FN_NOR   = 6'd39;
    localparam logic [5:0] FN_SLT   = 6'd42;
    localparam logic [5:0] FN_SLTU  = 6'd43;

    // REGIMM branches select on the rt field
    localparam logic [4:0] RT_BLTZ   = 5'd0;
    localparam logic [4:0] RT_BGEZ   = 5'd1;
    localparam logic [4:0] RT_BLTZAL = 5'd16;
    localparam logic [4:0] RT_BGEZAL = 5'd17;

    localparam logic [4:0]      LINK_REG    = 5'd31;
    localparam logic [XLEN-1:0] LINK_OFFSET = 32'd8; // return past the delay slot

    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_t;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic [4:0]  raddr_a,
    input  logic [4:0]  raddr_b,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32]; // no reset, contents undefined until written

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // reads see the state before this edge's write
    assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];

endmodule

// ==== design/hi_lo_regs.sv ====
`timescale 1ns/1ps

module hi_lo_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        hi_we,
    input  logic        lo_we,
    input  logic [31:0] hi_d,
    input  logic [31:0] lo_d,
    output logic [31:0] hi_q,
    output logic [31:0] lo_q
);

    // separate enables so mthi / mtlo leave the other half alone
    always_ff @(posedge clk) begin
        if (rst) begin
            hi_q <= 32'd0;
        end else if (hi_we) begin
            hi_q <= hi_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lo_q <= 32'd0;
        end else if (lo_we) begin
            lo_q <= lo_d;
        end
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  mips_pkg::instr_t              instr,
    input  logic                          valid,
    input  logic [mips_pkg::XLEN-1:0]     op1,   // rs value
    input  logic [mips_pkg::XLEN-1:0]     op2,   // rt value
    input  logic [mips_pkg::XLEN-1:0]     hi_q,
    input  logic [mips_pkg::XLEN-1:0]     lo_q,
    output logic [mips_pkg::XLEN-1:0]     result,
    output logic [mips_pkg::XLEN-1:0]     hi_d,
    output logic [mips_pkg::XLEN-1:0]     lo_d,
    output logic                          hi_we,
    output logic                          lo_we,
    output logic                          b_flag,
    output logic                          link,
    output logic                          write_reg,
    output logic                          mem_en,
    output logic [mips_pkg::XLEN-1:0]     mem_addr_calc
);

    import mips_pkg::*;

    logic [XLEN-1:0]          simm;   // sign extended imm
    logic [XLEN-1:0]          zimm;   // zero extended imm
    logic [4:0]               shift_v;
    logic signed [2*XLEN-1:0] prod_s;
    logic [2*XLEN-1:0]        prod_u;
    logic                     div_zero;

    assign simm     = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign zimm     = {16'd0, instr.i.imm};
    assign shift_v  = op1[4:0];       // variable shifts use low 5 bits of rs
    assign prod_s   = $signed(op1) * $signed(op2);
    assign prod_u   = op1 * op2;
    assign div_zero = (op2 == '0);

    always_comb begin
        result        = '0;
        hi_d          = '0;
        lo_d          = '0;
        hi_we         = 1'b0;
        lo_we         = 1'b0;
        b_flag        = 1'b0;
        link          = 1'b0;
        write_reg     = 1'b0;
        mem_en        = 1'b0;
        mem_addr_calc = '0;

        case (instr.r.opcode)
            OP_SPECIAL: begin
                write_reg = 1'b1; // cleared below for hi/lo and unknown functs
                case (instr.r.funct)
                    FN_SLL:  result = op2 << instr.r.shamt;
                    FN_SRL:  result = op2 >> instr.r.shamt;
                    FN_SRA:  result = $signed(op2) >>> instr.r.shamt;
                    FN_SLLV: result = op2 << shift_v;
                    FN_SRLV: result = op2 >> shift_v;
                    FN_SRAV: result = $signed(op2) >>> shift_v;
                    FN_MFHI: result = hi_q;
                    FN_MFLO: result = lo_q;
                    FN_MTHI: begin
                        hi_d      = op1;
                        hi_we     = valid;
                        write_reg = 1'b0;
                    end
                    FN_MTLO: begin
                        lo_d      = op1;
                        lo_we     = valid;
                        write_reg = 1'b0;
                    end
                    FN_MULT: begin
                        hi_d      = prod_s[2*XLEN-1:XLEN];
                        lo_d      = prod_s[XLEN-1:0];
                        hi_we     = valid;
                        lo_we     = valid;
                        write_reg = 1'b0;
                    end
                    FN_MULTU: begin
                        hi_d      = prod_u[2*XLEN-1:XLEN];
                        lo_d      = prod_u[XLEN-1:0];
                        hi_we     = valid;
                        lo_we     = valid;
                        write_reg = 1'b0;
                    end
                    FN_DIV, FN_DIVU: begin
                        if (div_zero) begin
                            hi_d = op1;       // fixed rule for x/0
                            lo_d = '1;
                        end else if (instr.r.funct == FN_DIV) begin
                            hi_d = $signed(op1) % $signed(op2);
                            lo_d = $signed(op1) / $signed(op2);
                        end else begin
                            hi_d = op1 % op2;
                            lo_d = op1 / op2;
                        end
                        hi_we     = valid;
                        lo_we     = valid;
                        write_reg = 1'b0;
                    end
                    FN_ADD,
                    FN_ADDU: result = op1 + op2;  // no overflow trap
                    FN_SUB,
                    FN_SUBU: result = op1 - op2;
                    FN_AND:  result = op1 & op2;
                    FN_OR:   result = op1 | op2;
                    FN_XOR:  result = op1 ^ op2;
                    FN_NOR:  result = ~(op1 | op2);
                    FN_SLT:  result = {31'd0, $signed(op1) < $signed(op2)};
                    FN_SLTU: result = {31'd0, op1 < op2};
                    default: write_reg = 1'b0;
                endcase
            end
            OP_REGIMM: begin
                case (instr.i.rt)
                    RT_BLTZ:   b_flag = op1[31];
                    RT_BGEZ:   b_flag = ~op1[31];
                    RT_BLTZAL: begin
                        b_flag    = op1[31];
                        link      = 1'b1;  // r31 written taken or not
                        write_reg = 1'b1;
                    end
                    RT_BGEZAL: begin
                        b_flag    = ~op1[31];
                        link      = 1'b1;
                        write_reg = 1'b1;
                    end
                    default: b_flag = 1'b0;
                endcase
            end
            OP_BEQ:  b_flag = (op1 == op2);
            OP_BNE:  b_flag = (op1 != op2);
            OP_BLEZ: b_flag = op1[31] || (op1 == '0);
            OP_BGTZ: b_flag = !op1[31] && (op1 != '0);
            OP_ADDI, OP_ADDIU: begin
                result    = op1 + simm;
                write_reg = 1'b1;
            end
            OP_SLTI: begin
                result    = {31'd0, $signed(op1) < $signed(simm)};
                write_reg = 1'b1;
            end
            OP_SLTIU: begin
                result    = {31'd0, op1 < simm}; // sign extended, compared unsigned
                write_reg = 1'b1;
            end
            OP_ANDI: begin
                result    = op1 & zimm;
                write_reg = 1'b1;
            end
            OP_ORI: begin
                result    = op1 | zimm;
                write_reg = 1'b1;
            end
            OP_XORI: begin
                result    = op1 ^ zimm;
                write_reg = 1'b1;
            end
            OP_LUI: begin
                result    = {instr.i.imm, 16'd0};
                write_reg = 1'b1;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: begin
                mem_en        = 1'b1; // address only, no load data here
                mem_addr_calc = op1 + simm;
            end
            default: result = '0;
        endcase
    end

endmodule

// ==== design/writeback_ctrl.sv ====
`timescale 1ns/1ps

module writeback_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid,
    input  mips_pkg::instr_t          instr,
    input  logic [mips_pkg::XLEN-1:0] pc,
    input  logic [mips_pkg::XLEN-1:0] result,
    input  logic                      b_flag,
    input  logic                      link,
    input  logic                      write_reg,
    input  logic                      mem_en,
    input  logic [mips_pkg::XLEN-1:0] mem_addr_calc,
    output logic                      rf_we,
    output logic [4:0]                rf_waddr,
    output logic [mips_pkg::XLEN-1:0] rf_wdata,
    output logic                      wb_en,
    output logic [4:0]                wb_addr,
    output logic [mips_pkg::XLEN-1:0] wb_data,
    output logic                      branch_taken,
    output logic                      mem_access,
    output logic [mips_pkg::XLEN-1:0] mem_addr
);

    import mips_pkg::*;

    // link beats the format-based choice
    always_comb begin
        if (link) begin
            rf_waddr = LINK_REG;
        end else if (instr.r.opcode == OP_SPECIAL) begin
            rf_waddr = instr.r.rd;
        end else begin
            rf_waddr = instr.i.rt;
        end
    end

    assign rf_we    = valid & write_reg;
    assign rf_wdata = link ? (pc + LINK_OFFSET) : result;

    // outputs live for one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst || !valid) begin
            wb_en        <= 1'b0;
            wb_addr      <= '0;
            wb_data      <= '0;
            branch_taken <= 1'b0;
            mem_access   <= 1'b0;
            mem_addr     <= '0;
        end else begin
            wb_en        <= write_reg;
            wb_addr      <= write_reg ? rf_waddr : 5'd0;
            wb_data      <= write_reg ? rf_wdata : '0;
            branch_taken <= b_flag;
            mem_access   <= mem_en;
            mem_addr     <= mem_en ? mem_addr_calc : '0;
        end
    end

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  mips_pkg::instr_t          instr,
    input  logic [mips_pkg::XLEN-1:0] pc,
    output logic                      wb_en,
    output logic [4:0]                wb_addr,
    output logic [mips_pkg::XLEN-1:0] wb_data,
    output logic                      branch_taken,
    output logic                      mem_access,
    output logic [mips_pkg::XLEN-1:0] mem_addr
);

    import mips_pkg::*;

    logic [XLEN-1:0] rs_data;
    logic [XLEN-1:0] rt_data;
    logic [XLEN-1:0] hi_q;
    logic [XLEN-1:0] lo_q;
    logic [XLEN-1:0] hi_d;
    logic [XLEN-1:0] lo_d;
    logic            hi_we;
    logic            lo_we;
    logic [XLEN-1:0] result;
    logic            b_flag;
    logic            link;
    logic            write_reg;
    logic            mem_en;
    logic [XLEN-1:0] mem_addr_calc;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;

    reg_file u_reg_file (
        .clk     (clk),
        .raddr_a (instr.r.rs),
        .raddr_b (instr.r.rt),
        .rdata_a (rs_data),
        .rdata_b (rt_data),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    alu u_alu (
        .instr         (instr),
        .valid         (instr_valid),
        .op1           (rs_data),
        .op2           (rt_data),
        .hi_q          (hi_q),
        .lo_q          (lo_q),
        .result        (result),
        .hi_d          (hi_d),
        .lo_d          (lo_d),
        .hi_we         (hi_we),
        .lo_we         (lo_we),
        .b_flag        (b_flag),
        .link          (link),
        .write_reg     (write_reg),
        .mem_en        (mem_en),
        .mem_addr_calc (mem_addr_calc)
    );

    hi_lo_regs u_hi_lo_regs (
        .clk   (clk),
        .rst   (rst),
        .hi_we (hi_we),
        .lo_we (lo_we),
        .hi_d  (hi_d),
        .lo_d  (lo_d),
        .hi_q  (hi_q),
        .lo_q  (lo_q)
    );

    writeback_ctrl u_writeback_ctrl (
        .clk           (clk),
        .rst           (rst),
        .valid         (instr_valid),
        .instr         (instr),
        .pc            (pc),
        .result        (result),
        .b_flag        (b_flag),
        .link          (link),
        .write_reg     (write_reg),
        .mem_en        (mem_en),
        .mem_addr_calc (mem_addr_calc),
        .rf_we         (rf_we),
        .rf_waddr      (rf_waddr),
        .rf_wdata      (rf_wdata),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .mem_access    (mem_access),
        .mem_addr      (mem_addr)
    );

endmodule

// ==== sim/exec_ref_model.svh ====
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// one expected output set, as seen one cycle after the strobe
typedef struct packed {
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        branch_taken;
    logic        mem_access;
    logic [31:0] mem_addr;
} exp_t;

logic [31:0] m_regs [32];  // model register file, r0 never stored
logic [31:0] m_hi = '0;     // reset value of hi/lo
logic [31:0] m_lo = '0;

function automatic logic less_signed(logic [31:0] x, logic [31:0] y);
    return (x[31] != y[31]) ? x[31] : (x < y);  // sign bits differ, negative one wins
endfunction

function automatic logic [31:0] shift_right_arith(logic [31:0] v, logic [4:0] sh);
    return v[31] ? ~(~v >> sh) : (v >> sh);
endfunction

function automatic logic [31:0] imm_result(logic [5:0] op, logic [31:0] a, logic [15:0] imm);
    logic [31:0] sx;
    logic [31:0] zx;
    sx = {{16{imm[15]}}, imm};
    zx = {16'd0, imm};
    case (op)
        OP_SLTI:  return {31'd0, less_signed(a, sx)};
        OP_SLTIU: return {31'd0, a < sx};  // sign extended, unsigned compare
        OP_ANDI:  return a & zx;
        OP_ORI:   return a | zx;
        OP_XORI:  return a ^ zx;
        OP_LUI:   return {imm, 16'd0};
        default:  return a + sx;           // addi, addiu
    endcase
endfunction

function automatic void update_hi_lo(logic [5:0] fn, logic [31:0] a, logic [31:0] b);
    logic [63:0] p;
    case (fn)
        FN_MTHI: m_hi = a;
        FN_MTLO: m_lo = a;
        FN_MULT: begin
            p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            {m_hi, m_lo} = p;
        end
        FN_MULTU: begin
            p = {32'd0, a} * {32'd0, b};
            {m_hi, m_lo} = p;
        end
        FN_DIV, FN_DIVU: begin
            if (b == 32'd0) begin
                m_hi = a;             // divide by zero rule
                m_lo = 32'hffff_ffff;
            end else if (fn == FN_DIV) begin
                m_lo = $signed(a) / $signed(b);
                m_hi = $signed(a) % $signed(b);
            end else begin
                m_lo = a / b;
                m_hi = a % b;
            end
        end
        default: ;
    endcase
endfunction

function automatic exp_t predict(instr_t w, logic [31:0] pc_v);
    exp_t        e;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  dst;
    e   = '0;
    a   = (w.r.rs == 5'd0) ? 32'd0 : m_regs[w.r.rs];
    b   = (w.r.rt == 5'd0) ? 32'd0 : m_regs[w.r.rt];
    dst = w.i.rt;  // i-format destination
    case (w.r.opcode)
        OP_SPECIAL: begin
            dst     = w.r.rd;
            e.wb_en = 1'b1;
            case (w.r.funct)
                FN_SLL:          e.wb_data = b << w.r.shamt;
                FN_SRL:          e.wb_data = b >> w.r.shamt;
                FN_SRA:          e.wb_data = shift_right_arith(b, w.r.shamt);
                FN_SLLV:         e.wb_data = b << a[4:0];
                FN_SRLV:         e.wb_data = b >> a[4:0];
                FN_SRAV:         e.wb_data = shift_right_arith(b, a[4:0]);
                FN_ADD, FN_ADDU: e.wb_data = a + b;
                FN_SUB, FN_SUBU: e.wb_data = a - b;
                FN_AND:          e.wb_data = a & b;
                FN_OR:           e.wb_data = a | b;
                FN_XOR:          e.wb_data = a ^ b;
                FN_NOR:          e.wb_data = ~(a | b);
                FN_SLT:          e.wb_data = {31'd0, less_signed(a, b)};
                FN_SLTU:         e.wb_data = {31'd0, a < b};
                FN_MFHI:         e.wb_data = m_hi;
                FN_MFLO:         e.wb_data = m_lo;
                default: begin
                    e.wb_en = 1'b0;  // hi/lo writers
                    update_hi_lo(w.r.funct, a, b);
                end
            endcase
        end
        OP_REGIMM: begin
            e.branch_taken = (w.i.rt == RT_BLTZ || w.i.rt == RT_BLTZAL) ? a[31] : !a[31];
            if (w.i.rt == RT_BLTZAL || w.i.rt == RT_BGEZAL) begin
                e.wb_en   = 1'b1;  // link whether taken or not
                e.wb_data = pc_v + LINK_OFFSET;
                dst       = LINK_REG;
            end
        end
        OP_BEQ:  e.branch_taken = (a == b);
        OP_BNE:  e.branch_taken = (a != b);
        OP_BLEZ: e.branch_taken = ($signed(a) <= 0);
        OP_BGTZ: e.branch_taken = ($signed(a) > 0);
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            e.wb_en   = 1'b1;
            e.wb_data = imm_result(w.r.opcode, a, w.i.imm);
        end
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: begin
            e.mem_access = 1'b1;
            e.mem_addr   = a + {{16{w.i.imm[15]}}, w.i.imm};
        end
        default: ;
    endcase
    if (e.wb_en) begin
        e.wb_addr = dst;
        if (dst != 5'd0) m_regs[dst] = e.wb_data;
    end
    return e;
endfunction

`endif

// ==== sim/tb_execute_unit.sv ====
`timescale 1ns/1ps

module tb_execute_unit;

    import mips_pkg::*;

    logic            clk;
    logic            rst;
    logic            instr_valid;
    instr_t          instr;
    logic [XLEN-1:0] pc;
    logic            wb_en;
    logic [4:0]      wb_addr;
    logic [XLEN-1:0] wb_data;
    logic            branch_taken;
    logic            mem_access;
    logic [XLEN-1:0] mem_addr;

    `include "exec_ref_model.svh"

    integer          seed = 32'h3e49;
    logic [XLEN-1:0] pc_next;
    exp_t            exp_q [$];  // one entry per driven cycle
    logic [31:0]     r;
    int              i;
    int              j;
    int              k;

    logic [5:0] r_fns [16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR,
        FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
    logic [5:0] i_ops [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
        OP_XORI, OP_LUI};
    logic [5:0] m_ops [8] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
    logic [5:0] md_fns [4] = '{FN_MULT, FN_MULTU, FN_DIV, FN_DIVU};
    logic [4:0] rt_codes [4] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};

    execute_unit dut (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .branch_taken (branch_taken),
        .mem_access   (mem_access),
        .mem_addr     (mem_addr)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [15:0] rnd16();
        logic [31:0] v;
        v = $random(seed);
        return v[15:0];
    endfunction

    function automatic logic [4:0] rnd5();
        logic [31:0] v;
        v = $random(seed);
        return v[4:0];
    endfunction

    function automatic instr_t r_op(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                    logic [4:0] rd, logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic instr_t i_op(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic issue(instr_t w);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        pc          <= pc_next;
        exp_q.push_back(predict(w, pc_next));
        pc_next = pc_next + 32'd4;
    endtask

    task automatic idle();
        @(posedge clk);
        instr_valid <= 1'b0;
        exp_q.push_back('0);  // all pulses low after a gap
    endtask

    task automatic maybe_idle();
        logic [31:0] v;
        v = rnd();
        if (v[1:0] == 2'd0) idle();
    endtask

    task automatic check_val(string name, logic [31:0] act, logic [31:0] want);
        assert (act === want) else begin
            $display("[ERROR] %s expected 0x%h got 0x%h", name, want, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // outputs settle after the edge, so compare at the falling edge
    always @(negedge clk) begin : compare_outputs
        exp_t e;
        if (exp_q.size() > 1) begin
            e = exp_q.pop_front();
            check_val("wb_en", 32'(wb_en), 32'(e.wb_en));
            check_val("branch_taken", 32'(branch_taken), 32'(e.branch_taken));
            check_val("mem_access", 32'(mem_access), 32'(e.mem_access));
            if (e.wb_en) begin
                check_val("wb_addr", 32'(wb_addr), 32'(e.wb_addr));
                check_val("wb_data", wb_data, e.wb_data);
            end
            if (e.mem_access) check_val("mem_addr", mem_addr, e.mem_addr);
        end
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b1;  // strobes under reset must not reach the outputs
        instr       = i_op(OP_ADDI, 5'd0, 5'd0, 16'h0001);
        pc          = '0;
        repeat (3) @(posedge clk);
        instr <= i_op(OP_BEQ, 5'd0, 5'd0, 16'h0010);  // would raise branch_taken
        repeat (3) @(posedge clk);
        instr <= i_op(OP_LW, 5'd0, 5'd0, 16'h0010);   // would raise mem_access
        repeat (4) @(posedge clk);
        rst         <= 1'b0;
        instr_valid <= 1'b0;
    end

    initial begin
        pc_next = 32'h0040_0000;
        for (k = 0; k < 40 && rst !== 1'b0; k++) begin
            @(negedge clk);
            check_val("wb_en", 32'(wb_en), 32'd0);
            check_val("branch_taken", 32'(branch_taken), 32'd0);
            check_val("mem_access", 32'(mem_access), 32'd0);
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset was never released");
            $display("Finished with errors");
            $fatal(1);
        end

        // seed every register, then widen to full 32-bit values
        for (i = 1; i < 32; i++) issue(i_op(OP_ADDI, 5'd0, 5'(i), rnd16()));
        for (i = 1; i < 32; i++) begin
            issue(i_op(OP_LUI, 5'd0, 5'(i), rnd16()));
            issue(i_op(OP_ORI, 5'(i), 5'(i), rnd16()));
        end

        for (i = 0; i < 150; i++) begin
            r = rnd();
            issue(r_op(r_fns[r[3:0]], rnd5(), rnd5(), rnd5(), rnd5()));
            maybe_idle();
        end

        for (i = 0; i < 80; i++) begin
            r = rnd();
            issue(i_op(i_ops[r[2:0]], rnd5(), rnd5(), rnd16()));
        end
        issue(i_op(OP_ADDI, 5'd5, 5'd0, 16'h1234));  // r0 must stay zero
        issue(r_op(FN_ADDU, 5'd0, 5'd0, 5'd7, 5'd0));
        issue(r_op(FN_ADDU, 5'd0, 5'd6, 5'd7, 5'd0));

        for (i = 0; i < 40; i++) begin
            r = rnd();
            issue(r_op(md_fns[r[1:0]], rnd5(), rnd5(), 5'd0, 5'd0));
            issue(r_op(FN_MFHI, 5'd0, 5'd0, rnd5(), 5'd0));
            issue(r_op(FN_MFLO, 5'd0, 5'd0, rnd5(), 5'd0));
        end
        issue(r_op(FN_DIV, 5'd9, 5'd0, 5'd0, 5'd0));   // rt = r0 gives x/0
        issue(r_op(FN_MFHI, 5'd0, 5'd0, 5'd10, 5'd0));
        issue(r_op(FN_MFLO, 5'd0, 5'd0, 5'd11, 5'd0));
        issue(r_op(FN_DIVU, 5'd12, 5'd0, 5'd0, 5'd0));
        issue(r_op(FN_MFHI, 5'd0, 5'd0, 5'd10, 5'd0));
        issue(r_op(FN_MFLO, 5'd0, 5'd0, 5'd11, 5'd0));
        issue(r_op(FN_MTHI, 5'd3, 5'd0, 5'd0, 5'd0));
        issue(r_op(FN_MFHI, 5'd0, 5'd0, 5'd10, 5'd0));
        issue(r_op(FN_MFLO, 5'd0, 5'd0, 5'd11, 5'd0));
        issue(r_op(FN_MTLO, 5'd4, 5'd0, 5'd0, 5'd0));
        issue(r_op(FN_MFHI, 5'd0, 5'd0, 5'd10, 5'd0));
        issue(r_op(FN_MFLO, 5'd0, 5'd0, 5'd11, 5'd0));

        // zero, positive and negative sources, r4 equals r2
        issue(i_op(OP_ADDI, 5'd0, 5'd1, 16'h0000));
        issue(i_op(OP_ADDI, 5'd0, 5'd2, 16'h0005));
        issue(i_op(OP_ADDI, 5'd0, 5'd3, 16'hfffb));
        issue(i_op(OP_ADDI, 5'd0, 5'd4, 16'h0005));
        for (k = 1; k < 4; k++) begin
            issue(i_op(OP_BEQ, 5'(k), 5'd4, 16'h0010));
            issue(i_op(OP_BNE, 5'(k), 5'd4, 16'h0010));
            issue(i_op(OP_BLEZ, 5'(k), 5'd0, 16'h0010));
            issue(i_op(OP_BGTZ, 5'(k), 5'd0, 16'h0010));
            for (j = 0; j < 4; j++) issue(i_op(OP_REGIMM, 5'(k), rt_codes[j], 16'h0020));
            issue(r_op(FN_ADDU, 5'd31, 5'd0, 5'd8, 5'd0));  // read back link
        end

        for (i = 0; i < 40; i++) begin
            r = rnd();
            issue(i_op(m_ops[r[2:0]], rnd5(), rnd5(), rnd16()));
            maybe_idle();
        end

        idle();
        idle();
        for (k = 0; k < 20 && exp_q.size() > 1; k++) @(posedge clk);
        if (exp_q.size() > 1) begin
            $display("Timeout: outputs of the last instructions were never compared");
            $display("Finished with errors");
            $fatal(1);
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+sim
design/mips_pkg.sv
design/reg_file.sv
design/hi_lo_regs.sv
design/alu.sv
design/writeback_ctrl.sv
design/execute_unit.sv
sim/tb_execute_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_execute_unit
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
